// ==== mul_cmd_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mul_config.svh"

module mul_cmd_ctrl (
   input  logic              pll_clk,
   input  logic              i_nrst,
   input  mul_pkg::rx_byte_t i_rx,
   output mul_pkg::tx_req_t  o_tx_req,
   output mul_pkg::mul_req_t o_mul_req,
   output logic              o_mul_valid,
   input  logic              i_mul_accept,
   input  mul_pkg::product_t i_product
);

   import mul_pkg::*;

   ctrl_state_e state_q;
   cmd_e        cmd;
   nibble_t     nib;
   operand_a_t  a_q;
   operand_b_t  b_q;
   product_t    prod_q;   // Shifts down on every read
   uart_byte_t  tx_byte_q;
   logic        tx_start_q;

   assign cmd = cmd_e'(i_rx.data[3:0]);
   assign nib = i_rx.data[7:4];

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state_q    <= LOADING;
         a_q        <= '0;
         b_q        <= '0;
         prod_q     <= '0;
         tx_start_q <= 1'b0;
      end else begin
         tx_start_q <= 1'b0;
         case (state_q)
            LOADING: if (i_rx.valid) begin
               case (cmd)
                  LOAD_A: a_q <= {a_q[`MUL_WIDTH_A-5:0], nib};
                  LOAD_B: b_q <= {b_q[`MUL_WIDTH_B-5:0], nib};
                  READ_P: begin
                     prod_q     <= prod_q >> 8;   // Zeros fill from the top
                     tx_start_q <= 1'b1;
                  end
                  START:   state_q <= MULTIPLYING;
                  default: ;   // Codes 4 to F do nothing
               endcase
            end
            MULTIPLYING: if (i_mul_accept) begin
               prod_q  <= i_product;
               state_q <= LOADING;
            end
            default: state_q <= LOADING;
         endcase
      end
   end

   // Byte captured before the shift takes it away
   always_ff @(posedge pll_clk) begin
      if (state_q == LOADING && i_rx.valid && cmd == READ_P) tx_byte_q <= prod_q[7:0];
   end

   assign o_tx_req.start = tx_start_q;
   assign o_tx_req.data  = tx_byte_q;
   assign o_mul_req.a    = a_q;
   assign o_mul_req.b    = b_q;
   assign o_mul_valid    = (state_q == MULTIPLYING);

endmodule

`default_nettype wire

// ==== mul_config.svh ====
`ifndef MUL_CONFIG_SVH
`define MUL_CONFIG_SVH

// Operand widths of the multiplier
`define MUL_WIDTH_A 32
`define MUL_WIDTH_B 32

// Full unsigned product
`define MUL_WIDTH_P 64

// Bit period counter, wide enough for slow host rates
`define BAUD_CNT_WIDTH 16

// Flops on the asynchronous serial input
`define RX_SYNC_STAGES 3

`endif

// ==== mul_pkg.sv ====
`default_nettype none

`include "mul_config.svh"

package mul_pkg;

   typedef logic [`MUL_WIDTH_A-1:0]    operand_a_t;
   typedef logic [`MUL_WIDTH_B-1:0]    operand_b_t;
   typedef logic [`MUL_WIDTH_P-1:0]    product_t;
   typedef logic [7:0]                 uart_byte_t;
   typedef logic [`BAUD_CNT_WIDTH-1:0] baud_div_t;   // Clock cycles per bit
   typedef logic [3:0]                 nibble_t;

   // Command code sits in the low nibble of a received byte
   typedef enum logic [3:0] {
      LOAD_A = 4'h0,
      LOAD_B = 4'h1,
      READ_P = 4'h2,
      START  = 4'h3
   } cmd_e;

   typedef enum logic {
      LOADING,
      MULTIPLYING
   } ctrl_state_e;

   typedef enum logic [2:0] {
      RX_MEASURE,   // Waiting for the sync character
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_e;

   typedef struct packed {
      operand_a_t a;
      operand_b_t b;
   } mul_req_t;

   typedef struct packed {
      logic       valid;
      uart_byte_t data;
   } rx_byte_t;

   typedef struct packed {
      logic       start;
      uart_byte_t data;
   } tx_req_t;

endpackage

`default_nettype wire

// ==== mul_uart_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module mul_uart_asserts (
   input logic              pll_clk,
   input logic              i_nrst,
   input mul_pkg::rx_byte_t i_rx_byte,
   input logic              i_mul_valid,
   input logic              i_mul_accept,
   input logic              i_tx
);

   import mul_pkg::*;

   int   fail_cnt = 0;   // Failed properties so far
   logic read_seen_q;

   // First READ_P byte seen by the controller
   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         read_seen_q <= 1'b0;
      end else if (i_rx_byte.valid && i_rx_byte.data[3:0] == READ_P) begin
         read_seen_q <= 1'b1;
      end
   end

   rx_valid_pulse: assert property (@(posedge pll_clk) disable iff (!i_nrst)
      i_rx_byte.valid |=> !i_rx_byte.valid)
      else begin
         $error("Receiver valid strobe lasted more than one cycle");
         fail_cnt++;
      end

   accept_pulse: assert property (@(posedge pll_clk) disable iff (!i_nrst)
      i_mul_accept |=> !i_mul_accept)
      else begin
         $error("Multiplier accept lasted more than one cycle");
         fail_cnt++;
      end

   accept_in_valid: assert property (@(posedge pll_clk) disable iff (!i_nrst)
      i_mul_accept |-> i_mul_valid)
      else begin
         $error("Multiplier accept without a pending request");
         fail_cnt++;
      end

   valid_drop: assert property (@(posedge pll_clk) disable iff (!i_nrst)
      i_mul_accept |=> !i_mul_valid)
      else begin
         $error("Request still valid the cycle after accept");
         fail_cnt++;
      end

   // Nothing to send before the host asks for a byte
   tx_idle: assert property (@(posedge pll_clk) disable iff (!i_nrst)
      !read_seen_q |-> i_tx)
      else begin
         $error("Serial output left idle before any read command");
         fail_cnt++;
      end

endmodule

bind mul_uart_top mul_uart_asserts u_asserts (
   .pll_clk      (pll_clk),
   .i_nrst       (i_nrst),
   .i_rx_byte    (rx_byte),
   .i_mul_valid  (mul_valid),
   .i_mul_accept (mul_accept),
   .i_tx         (o_tx)
);

`default_nettype wire

// ==== mul_uart_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mul_config.svh"

module mul_uart_tb;

   import mul_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int BIT_CYCLES = 16;
   // Line frames over all tests with two per read
   localparam int FRAMES     = 5 + 33 + 3 * 33 + 4 + 70 + 20;
   localparam int TIMEOUT_NS = FRAMES * 10 * BIT_CYCLES * CLK_PERIOD * 12 / 10;

   logic       pll_clk = 1'b0;
   logic       i_nrst  = 1'b0;
   logic       i_rx    = 1'b1;   // Idle line level
   logic       o_tx;
   operand_a_t a_m;
   operand_b_t b_m;
   product_t   p_m;   // Model of the controller's product register
   integer     seed;

   mul_uart_top i_dut (
      .pll_clk (pll_clk),
      .i_nrst  (i_nrst),
      .i_rx    (i_rx),
      .o_tx    (o_tx)
   );

   initial begin
      forever #(CLK_PERIOD / 2) pll_clk = ~pll_clk;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   // One 8N1 frame plus an idle bit, driven on falling edges
   task automatic send_byte(input uart_byte_t data);
      i_rx = 1'b0;
      repeat (BIT_CYCLES) @(negedge pll_clk);
      for (int i = 0; i < 8; i++) begin
         i_rx = data[i];
         repeat (BIT_CYCLES) @(negedge pll_clk);
      end
      i_rx = 1'b1;
      repeat (2 * BIT_CYCLES) @(negedge pll_clk);
   endtask

   task automatic receive_byte(output uart_byte_t data);
      int wait_cnt;
      wait_cnt = 0;
      while (o_tx && wait_cnt <= 24 * BIT_CYCLES) begin
         @(negedge pll_clk);
         wait_cnt++;
      end
      assert (!o_tx) else report_failure("No reply frame on o_tx after a read command");
      repeat (BIT_CYCLES / 2) @(negedge pll_clk);   // Middle of the start bit
      assert (!o_tx) else report_failure("Start bit on o_tx shorter than half a bit");
      for (int i = 0; i < 8; i++) begin
         repeat (BIT_CYCLES) @(negedge pll_clk);
         data[i] = o_tx;
      end
      repeat (BIT_CYCLES) @(negedge pll_clk);
      assert (o_tx) else report_failure("Reply frame on o_tx has a low stop bit");
   endtask

   task automatic read_check(input string name, input int idx);
      uart_byte_t got;
      uart_byte_t exp;
      exp = p_m[7:0];
      p_m = p_m >> 8;
      fork
         send_byte({4'h0, READ_P});
         receive_byte(got);
      join
      assert (got == exp) else
         report_failure($sformatf("[FAIL] %s byte %0d: expected 0x%02h, actual 0x%02h",
                                  name, idx, exp, got));
   endtask

   task automatic read_product(input string name);
      for (int i = 0; i < 8; i++) begin
         read_check(name, i);
      end
   endtask

   // Most significant nibble goes first
   task automatic load_a(input operand_a_t value, input int count);
      nibble_t nib;
      for (int i = count - 1; i >= 0; i--) begin
         nib = value[4*i +: 4];
         send_byte({nib, LOAD_A});
         a_m = (a_m << 4) | operand_a_t'(nib);
      end
   endtask

   task automatic load_b(input operand_b_t value, input int count);
      nibble_t nib;
      for (int i = count - 1; i >= 0; i--) begin
         nib = value[4*i +: 4];
         send_byte({nib, LOAD_B});
         b_m = (b_m << 4) | operand_b_t'(nib);
      end
   endtask

   task automatic multiply();
      send_byte({4'h0, START});
      p_m = product_t'(a_m) * product_t'(b_m);
   endtask

   initial begin
      #(TIMEOUT_NS);
      report_failure($sformatf("Timeout, run not finished after %0d ns", TIMEOUT_NS));
   end

   always @(negedge pll_clk) begin
      if (i_dut.u_asserts.fail_cnt != 0) report_failure("A protocol assertion in the DUT failed");
   end

   initial begin
      seed = 32'h7b557f94;
      a_m  = '0;
      b_m  = '0;
      p_m  = '0;
      repeat (5) @(negedge pll_clk);
      i_nrst = 1'b1;
      repeat (4) @(negedge pll_clk);

      // Sync byte, then a quiet line and one read at the host rate
      send_byte(8'h55);
      repeat (20 * BIT_CYCLES) @(negedge pll_clk);
      read_check("autobaud", 0);

      load_a($random(seed), 8);
      load_b($random(seed), 8);
      multiply();
      read_product("random");

      load_a('0, 8);
      load_b($random(seed), 8);
      multiply();
      read_product("zero_times_value");
      load_a('1, 8);
      load_b('1, 8);
      multiply();
      read_product("all_ones");
      load_a(operand_a_t'(1), 8);
      load_b($random(seed), 8);
      multiply();
      read_product("one_times_value");

      read_check("read_past_end", 8);   // Register already shifted empty
      read_check("read_past_end", 9);

      load_a($random(seed), 8);
      load_b($random(seed), 8);
      for (int c = 4; c < 16; c++) begin
         send_byte({nibble_t'($random(seed)), nibble_t'(c)});
      end
      multiply();
      read_product("ignored_codes");
      load_b($random(seed), 8);
      multiply();
      read_product("retention_new_b");

      load_a($random(seed), 3);   // Upper nibbles move up, not cleared
      multiply();
      read_product("partial_load");

      if (i_dut.u_asserts.fail_cnt != 0) begin
         report_failure("A protocol assertion in the DUT failed");
      end else begin
         $display("Test passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== mul_uart_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mul_uart_top (
   input  logic pll_clk,
   input  logic i_nrst,
   input  logic i_rx,
   output logic o_tx
);

   import mul_pkg::*;

   rx_byte_t  rx_byte;
   tx_req_t   tx_req;
   baud_div_t baud_div;   // Measured by the receiver, reused for transmit
   mul_req_t  mul_req;
   logic      mul_valid;
   logic      mul_accept;
   product_t  product;

   uart_rx_autobaud u_rx (
      .pll_clk    (pll_clk),
      .i_nrst     (i_nrst),
      .i_rx       (i_rx),
      .o_rx       (rx_byte),
      .o_baud_div (baud_div)
   );

   uart_tx u_tx (
      .pll_clk    (pll_clk),
      .i_nrst     (i_nrst),
      .i_tx_req   (tx_req),
      .i_baud_div (baud_div),
      .o_tx       (o_tx)
   );

   mul_cmd_ctrl u_ctrl (
      .pll_clk      (pll_clk),
      .i_nrst       (i_nrst),
      .i_rx         (rx_byte),
      .o_tx_req     (tx_req),
      .o_mul_req    (mul_req),
      .o_mul_valid  (mul_valid),
      .i_mul_accept (mul_accept),
      .i_product    (product)
   );

   seq_multiplier u_mul (
      .pll_clk   (pll_clk),
      .i_nrst    (i_nrst),
      .i_a       (mul_req.a),
      .i_b       (mul_req.b),
      .i_valid   (mul_valid),
      .o_product (product),
      .o_accept  (mul_accept)
   );

endmodule

`default_nettype wire

// ==== seq_multiplier.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mul_config.svh"

module seq_multiplier #(
   parameter int DATA_WIDTH_A = `MUL_WIDTH_A,
   parameter int DATA_WIDTH_B = `MUL_WIDTH_B
) (
   input  logic                    pll_clk,
   input  logic                    i_nrst,
   input  logic [DATA_WIDTH_A-1:0] i_a,
   input  logic [DATA_WIDTH_B-1:0] i_b,
   input  logic                    i_valid,
   output mul_pkg::product_t       o_product,
   output logic                    o_accept
);

   localparam int P_WIDTH = DATA_WIDTH_A + DATA_WIDTH_B;
   localparam int CNT_W   = $clog2(DATA_WIDTH_B);

   logic               busy_q;
   logic               done_q;   // Result handed over, wait for valid to drop
   logic               accept_q;
   logic [CNT_W-1:0]   cnt_q;
   logic               load;
   logic [P_WIDTH-1:0] acc_q;
   logic [P_WIDTH-1:0] mcand_q;
   logic [DATA_WIDTH_B-1:0] mplier_q;

   assign load = i_valid && !busy_q && !done_q;

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy_q   <= 1'b0;
         done_q   <= 1'b0;
         accept_q <= 1'b0;
         cnt_q    <= '0;
      end else begin
         accept_q <= 1'b0;
         if (load) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
         end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(DATA_WIDTH_B - 1)) begin   // Last multiplier bit
               busy_q   <= 1'b0;
               done_q   <= 1'b1;
               accept_q <= 1'b1;
            end
         end else if (done_q && !i_valid) begin
            done_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge pll_clk) begin
      if (load) begin
         acc_q    <= '0;
         mcand_q  <= P_WIDTH'(i_a);
         mplier_q <= i_b;
      end else if (busy_q) begin
         if (mplier_q[0]) acc_q <= acc_q + mcand_q;
         mcand_q  <= mcand_q << 1;
         mplier_q <= mplier_q >> 1;
      end
   end

   assign o_product = acc_q;
   assign o_accept  = accept_q;

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
mul_pkg.sv
uart_rx_autobaud.sv
uart_tx.sv
seq_multiplier.sv
mul_cmd_ctrl.sv
mul_uart_top.sv
mul_uart_asserts.sv
mul_uart_tb.sv

// ==== uart_rx_autobaud.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mul_config.svh"

module uart_rx_autobaud (
   input  logic               pll_clk,
   input  logic               i_nrst,
   input  logic               i_rx,
   output mul_pkg::rx_byte_t  o_rx,
   output mul_pkg::baud_div_t o_baud_div
);

   import mul_pkg::*;

   logic [`RX_SYNC_STAGES-1:0] sync_q;
   logic                       rx_s;
   rx_state_e                  state_q;
   baud_div_t                  cnt_q;
   baud_div_t                  baud_div_q;
   baud_div_t                  half_div;
   logic                       bit_end;
   logic [2:0]                 bit_cnt_q;
   uart_byte_t                 shift_q;
   logic                       locked_q;   // Set once the sync character is through
   logic                       valid_q;

   assign rx_s     = sync_q[`RX_SYNC_STAGES-1];
   assign half_div = baud_div_q >> 1;
   assign bit_end  = (cnt_q == baud_div_q - baud_div_t'(1));

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         sync_q     <= '1;   // Idle line level
         state_q    <= RX_MEASURE;
         cnt_q      <= '0;
         baud_div_q <= '0;
         bit_cnt_q  <= '0;
         locked_q   <= 1'b0;
         valid_q    <= 1'b0;
      end else begin
         sync_q  <= {sync_q[`RX_SYNC_STAGES-2:0], i_rx};
         valid_q <= 1'b0;
         case (state_q)
            RX_MEASURE: begin
               if (!rx_s) begin
                  cnt_q <= cnt_q + baud_div_t'(1);   // Low width of the start bit
               end else if (cnt_q != '0) begin
                  baud_div_q <= cnt_q;
                  // Land mid-bit in data bit 0, rest of the frame is discarded
                  cnt_q      <= cnt_q >> 1;
                  bit_cnt_q  <= '0;
                  state_q    <= RX_DATA;
               end
            end
            RX_IDLE: begin
               cnt_q <= '0;
               if (!rx_s) state_q <= RX_START;
            end
            RX_START: begin
               if (cnt_q == half_div) begin
                  cnt_q     <= '0;
                  bit_cnt_q <= '0;
                  state_q   <= rx_s ? RX_IDLE : RX_DATA;   // Drop short glitches
               end else begin
                  cnt_q <= cnt_q + baud_div_t'(1);
               end
            end
            RX_DATA: begin
               if (bit_end) begin
                  cnt_q     <= '0;
                  bit_cnt_q <= bit_cnt_q + 3'd1;
                  if (bit_cnt_q == 3'd7) state_q <= RX_STOP;
               end else begin
                  cnt_q <= cnt_q + baud_div_t'(1);
               end
            end
            RX_STOP: begin
               if (bit_end) begin
                  cnt_q    <= '0;
                  valid_q  <= locked_q;   // Sync byte is never delivered
                  locked_q <= 1'b1;
                  state_q  <= RX_IDLE;
               end else begin
                  cnt_q <= cnt_q + baud_div_t'(1);
               end
            end
            default: state_q <= RX_IDLE;
         endcase
      end
   end

   // LSB arrives first
   always_ff @(posedge pll_clk) begin
      if (state_q == RX_DATA && bit_end) shift_q <= {rx_s, shift_q[7:1]};
   end

   assign o_rx.valid = valid_q;
   assign o_rx.data  = shift_q;
   assign o_baud_div = baud_div_q;

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
   input  logic               pll_clk,
   input  logic               i_nrst,
   input  mul_pkg::tx_req_t   i_tx_req,
   input  mul_pkg::baud_div_t i_baud_div,
   output logic               o_tx
);

   import mul_pkg::*;

   tx_state_e  state_q;
   baud_div_t  cnt_q;
   logic [2:0] bit_cnt_q;
   logic       bit_end;
   uart_byte_t shift_q;
   logic       tx_q;

   assign bit_end = (cnt_q == i_baud_div - baud_div_t'(1));

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state_q   <= TX_IDLE;
         cnt_q     <= '0;
         bit_cnt_q <= '0;
         tx_q      <= 1'b1;
      end else begin
         cnt_q <= bit_end ? '0 : cnt_q + baud_div_t'(1);
         case (state_q)
            TX_IDLE: begin
               cnt_q <= '0;
               if (i_tx_req.start) begin
                  tx_q    <= 1'b0;   // Start bit on the next cycle
                  state_q <= TX_START;
               end
            end
            TX_START: if (bit_end) begin
               tx_q      <= shift_q[0];
               bit_cnt_q <= '0;
               state_q   <= TX_DATA;
            end
            TX_DATA: if (bit_end) begin
               bit_cnt_q <= bit_cnt_q + 3'd1;
               if (bit_cnt_q == 3'd7) begin
                  tx_q    <= 1'b1;   // Stop bit
                  state_q <= TX_STOP;
               end else begin
                  tx_q <= shift_q[1];
               end
            end
            TX_STOP: if (bit_end) state_q <= TX_IDLE;
            default: state_q <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge pll_clk) begin
      if (state_q == TX_IDLE && i_tx_req.start) begin
         shift_q <= i_tx_req.data;
      end else if (state_q == TX_DATA && bit_end) begin
         shift_q <= shift_q >> 1;
      end
   end

   assign o_tx = tx_q;

endmodule

`default_nettype wire
